// File: common/vga_pkg.sv
// VGA driver shared package with frame timing, register map, widths and pixel types
`default_nettype none

package vga_pkg;

  // Local bus geometry
  localparam int LB_ADDR_W = 8;
  localparam int LB_DATA_W = 32;

  // Register map
  localparam logic [LB_ADDR_W-1:0] VGA_CONTROL_REG_ADDR = 8'h00;
  localparam logic [LB_ADDR_W-1:0] VGA_STATUS_REG_ADDR  = 8'h04;
  localparam logic [LB_DATA_W-1:0] VGA_BAD_ADDR_DATA    = 32'hdeadbabe; // Unmapped read

  // Horizontal timing in pixels, reduced frame
  localparam int H_ACTIVE = 16;
  localparam int H_FP     = 2;
  localparam int H_SYNC   = 4;
  localparam int H_BP     = 2;
  localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;

  // Vertical timing in lines
  localparam int V_ACTIVE = 8;
  localparam int V_FP     = 1;
  localparam int V_SYNC   = 2;
  localparam int V_BP     = 1;
  localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

  localparam int H_CNT_W = $clog2(H_TOTAL); // 5 bits for 24 pixels
  localparam int V_CNT_W = $clog2(V_TOTAL); // 4 bits for 12 lines

  // Pixel buffer sizing
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = FIFO_PTR_W + 1; // Holds 0..FIFO_DEPTH

  typedef enum logic {
    mode_normal = 1'b0, // Pixels from FIFO
    mode_test   = 1'b1  // Computed pattern
  } vga_mode_e;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pixel_t;

  typedef struct packed {
    logic [LB_DATA_W-3:0] rsvd;
    vga_mode_e            mode;
    logic                 en;
  } vga_ctrl_word_t;

  typedef struct packed {
    logic [LB_DATA_W-3:0] rsvd;
    logic                 underflow;
    logic                 overflow;
  } vga_status_word_t;

  // Same 32 bit word, two register layouts
  typedef union packed {
    vga_ctrl_word_t   ctrl;
    vga_status_word_t status;
  } vga_reg_word_u;

endpackage

`default_nettype wire

// File: common/cr_intf.sv
// Clock and reset bundle shared by every VGA block
`timescale 1ns/1ns
`default_nettype none

interface cr_intf;

  logic clk;   // Pixel and bus clock
  logic rst_n; // Async reset, active low

  // Consumers only sample the pair
  modport sink (
    input clk,
    input rst_n
  );

endinterface

`default_nettype wire

// File: common/vga_ctrl_intf.sv
// Control and status bundle between the VGA register block and the driver
`timescale 1ns/1ns
`default_nettype none

interface vga_ctrl_intf
  import vga_pkg::*;
();

  logic      drvr_en;        // Driver enable from control reg
  vga_mode_e mode;           // Normal or test pattern
  logic      bffr_overflow;  // One cycle event from FIFO
  logic      bffr_underflow; // One cycle event from FIFO

  // Register block side
  modport lb (
    output drvr_en,
    output mode,
    input  bffr_overflow,
    input  bffr_underflow
  );

  // Driver side, timing and pixel path
  modport drvr (
    input  drvr_en,
    input  mode,
    output bffr_overflow,
    output bffr_underflow
  );

  // Buffer only reports its events
  modport fifo (
    output bffr_overflow,
    output bffr_underflow
  );

endinterface

`default_nettype wire

// File: vga/vga_lb.sv
// VGA register block decoding local bus accesses into control and sticky status
`timescale 1ns/1ns
`default_nettype none

module vga_lb
  import vga_pkg::*;
(
  cr_intf.sink               cr,
  input  wire  [LB_ADDR_W-1:0] addr,
  input  wire                  wr_en,
  input  wire  [LB_DATA_W-1:0] wr_data,
  input  wire                  rd_en,
  output logic [LB_DATA_W-1:0] rd_data,
  output logic                 wr_valid,
  output logic                 rd_valid,
  vga_ctrl_intf.lb             ctrl
);

  logic          drvr_en_q;
  vga_mode_e     mode_q;
  logic          overflow_q;  // Sticky
  logic          underflow_q; // Sticky
  logic          status_rd;   // Read hitting the status reg
  vga_reg_word_u wr_word;
  vga_reg_word_u rd_word;

  assign wr_word   = wr_data; // Bus word seen through the control layout
  assign status_rd = rd_en && (addr == VGA_STATUS_REG_ADDR);

  // Control register and bus echo pulses
  always_ff @(posedge cr.clk or negedge cr.rst_n)
  begin
    if (!cr.rst_n)
    begin
      drvr_en_q <= 1'b0;
      mode_q    <= mode_normal;
      wr_valid  <= 1'b0;
      rd_valid  <= 1'b0;
    end
    else
    begin
      if (wr_en && (addr == VGA_CONTROL_REG_ADDR)) // Other addresses ignored
      begin
        drvr_en_q <= wr_word.ctrl.en;
        mode_q    <= wr_word.ctrl.mode;
      end
      wr_valid <= wr_en;
      rd_valid <= rd_en;
    end
  end

  // Sticky flags; a new event beats the clearing read
  always_ff @(posedge cr.clk or negedge cr.rst_n)
  begin
    if (!cr.rst_n)
    begin
      overflow_q  <= 1'b0;
      underflow_q <= 1'b0;
    end
    else
    begin
      overflow_q  <= ctrl.bffr_overflow  | (overflow_q  & ~status_rd);
      underflow_q <= ctrl.bffr_underflow | (underflow_q & ~status_rd);
    end
  end

  // Read word built through the layout of the addressed register
  always_comb
  begin
    rd_word = '0;
    case (addr)
      VGA_CONTROL_REG_ADDR:
      begin
        rd_word.ctrl.en   = drvr_en_q;
        rd_word.ctrl.mode = mode_q;
      end
      VGA_STATUS_REG_ADDR:
      begin
        rd_word.status.underflow = underflow_q;
        rd_word.status.overflow  = overflow_q; // Pre-clear value returned
      end
      default: rd_word = VGA_BAD_ADDR_DATA;
    endcase
  end

  // Read data holds between reads
  always_ff @(posedge cr.clk)
  begin
    if (rd_en)
      rd_data <= rd_word;
  end

  assign ctrl.drvr_en = drvr_en_q;
  assign ctrl.mode    = mode_q;

  // Bus master issues one strobe at a time
  a_no_wr_rd_overlap: assert property (
    @(posedge cr.clk) disable iff (!cr.rst_n) !(wr_en && rd_en)
  );

endmodule

`default_nettype wire

// File: vga/vga_timing.sv
// VGA raster timing generator producing counters, sync windows and active area
`timescale 1ns/1ns
`default_nettype none

module vga_timing
  import vga_pkg::*;
(
  cr_intf.sink               cr,
  vga_ctrl_intf.drvr         ctrl,
  output logic [H_CNT_W-1:0] h_cnt,
  output logic [V_CNT_W-1:0] v_cnt,
  output logic               active,
  output logic               hsync_raw,
  output logic               vsync_raw
);

  logic h_active;
  logic v_active;
  logic h_in_sync;
  logic v_in_sync;

  // Pixel and line counters, parked at origin while disabled
  always_ff @(posedge cr.clk or negedge cr.rst_n)
  begin
    if (!cr.rst_n)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else if (!ctrl.drvr_en)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else if (h_cnt == H_CNT_W'(H_TOTAL - 1)) // End of line
    begin
      h_cnt <= '0;
      if (v_cnt == V_CNT_W'(V_TOTAL - 1))    // End of frame
        v_cnt <= '0;
      else
        v_cnt <= v_cnt + 1'b1;
    end
    else
    begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign h_active = h_cnt < H_CNT_W'(H_ACTIVE);
  assign v_active = v_cnt < V_CNT_W'(V_ACTIVE);

  // Sync follows the front porch
  assign h_in_sync = (h_cnt >= H_CNT_W'(H_ACTIVE + H_FP)) &&
                     (h_cnt <  H_CNT_W'(H_ACTIVE + H_FP + H_SYNC));
  assign v_in_sync = (v_cnt >= V_CNT_W'(V_ACTIVE + V_FP)) &&
                     (v_cnt <  V_CNT_W'(V_ACTIVE + V_FP + V_SYNC));

  // Origin is inside the active area, so qualify with enable
  assign active    = ctrl.drvr_en & h_active & v_active;
  assign hsync_raw = ctrl.drvr_en & h_in_sync; // Active high
  assign vsync_raw = ctrl.drvr_en & v_in_sync;

  a_h_cnt_range: assert property (
    @(posedge cr.clk) disable iff (!cr.rst_n) h_cnt < H_CNT_W'(H_TOTAL)
  );

endmodule

`default_nettype wire

// File: vga/pixel_fifo.sv
// Pixel buffer FIFO with overflow and underflow event reporting
`timescale 1ns/1ns
`default_nettype none

module pixel_fifo
  import vga_pkg::*;
(
  cr_intf.sink       cr,
  input  wire        pix_valid,
  input  pixel_t     pix_data,
  input  wire        pop,
  output pixel_t     pop_data,
  output logic       empty,
  vga_ctrl_intf.fifo ctrl
);

  pixel_t                mem [FIFO_DEPTH]; // Payload storage
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;            // Occupancy
  logic                  full;
  logic                  push_ok;
  logic                  pop_ok;

  assign full    = count == FIFO_CNT_W'(FIFO_DEPTH);
  assign empty   = count == '0;
  assign push_ok = pix_valid && !full; // Full drops the pixel
  assign pop_ok  = pop && !empty;

  always_ff @(posedge cr.clk)
  begin
    if (push_ok)
      mem[wr_ptr] <= pix_data;
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge cr.clk or negedge cr.rst_n)
  begin
    if (!cr.rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  assign pop_data = mem[rd_ptr]; // Show-ahead read

  assign ctrl.bffr_overflow  = pix_valid && full;
  assign ctrl.bffr_underflow = pop && empty;

  a_count_bound: assert property (
    @(posedge cr.clk) disable iff (!cr.rst_n) count <= FIFO_CNT_W'(FIFO_DEPTH)
  );

endmodule

`default_nettype wire

// File: vga/vga_pixel_out.sv
// VGA pixel output stage choosing buffered or test pattern pixels and registering video
`timescale 1ns/1ns
`default_nettype none

module vga_pixel_out
  import vga_pkg::*;
(
  cr_intf.sink              cr,
  vga_ctrl_intf.drvr        ctrl,
  input  wire [H_CNT_W-1:0] h_cnt,
  input  wire [V_CNT_W-1:0] v_cnt,
  input  wire               active,
  input  wire               hsync_raw,
  input  wire               vsync_raw,
  output logic              pop,
  input  pixel_t            pop_data,
  input  wire               empty,
  output logic              hsync,
  output logic              vsync,
  output logic              de,
  output pixel_t            rgb
);

  pixel_t test_pix;
  pixel_t pix_next;

  // Drain one pixel per active cycle in normal mode
  assign pop = ctrl.drvr_en && active && (ctrl.mode == mode_normal);

  // Pattern from raster position
  assign test_pix.r = 8'(h_cnt);
  assign test_pix.g = 8'(v_cnt);
  assign test_pix.b = test_pix.r ^ test_pix.g;

  always_comb
  begin
    if (!active)
      pix_next = '0;        // Blanking is black
    else if (ctrl.mode == mode_test)
      pix_next = test_pix;
    else if (empty)
      pix_next = '0;        // Underflow shows black
    else
      pix_next = pop_data;
  end

  // All video outputs share one register stage
  always_ff @(posedge cr.clk or negedge cr.rst_n)
  begin
    if (!cr.rst_n)
    begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      de    <= 1'b0;
      rgb   <= '0;
    end
    else
    begin
      hsync <= hsync_raw;
      vsync <= vsync_raw;
      de    <= active;
      rgb   <= pix_next;
    end
  end

endmodule

`default_nettype wire

// File: design/vga_top.sv
// VGA display driver top level joining register block, timing, buffer and output stage
`timescale 1ns/1ns
`default_nettype none

module vga_top
  import vga_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire  [LB_ADDR_W-1:0] addr,
  input  wire                  wr_en,
  input  wire  [LB_DATA_W-1:0] wr_data,
  input  wire                  rd_en,
  output logic [LB_DATA_W-1:0] rd_data,
  output logic                 wr_valid,
  output logic                 rd_valid,
  input  wire                  pix_valid,
  input  pixel_t               pix_data,
  output logic                 hsync,
  output logic                 vsync,
  output logic                 de,
  output pixel_t               rgb
);

  logic [H_CNT_W-1:0] h_cnt;
  logic [V_CNT_W-1:0] v_cnt;
  logic               active;
  logic               hsync_raw;
  logic               vsync_raw;
  logic               pop;
  pixel_t             pop_data;
  logic               empty;

  cr_intf       cr ();
  vga_ctrl_intf ctrl ();

  assign cr.clk   = clk;
  assign cr.rst_n = rst_n;

  // Register decode
  vga_lb u_lb (
    .cr       (cr),
    .addr     (addr),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .wr_valid (wr_valid),
    .rd_valid (rd_valid),
    .ctrl     (ctrl)
  );

  vga_timing u_timing (
    .cr        (cr),
    .ctrl      (ctrl),
    .h_cnt     (h_cnt),
    .v_cnt     (v_cnt),
    .active    (active),
    .hsync_raw (hsync_raw),
    .vsync_raw (vsync_raw)
  );

  pixel_fifo u_fifo (
    .cr        (cr),
    .pix_valid (pix_valid),
    .pix_data  (pix_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty),
    .ctrl      (ctrl)
  );

  // Result stage
  vga_pixel_out u_pixel_out (
    .cr        (cr),
    .ctrl      (ctrl),
    .h_cnt     (h_cnt),
    .v_cnt     (v_cnt),
    .active    (active),
    .hsync_raw (hsync_raw),
    .vsync_raw (vsync_raw),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty),
    .hsync     (hsync),
    .vsync     (vsync),
    .de        (de),
    .rgb       (rgb)
  );

endmodule

`default_nettype wire

// File: verification/vga_top_tb.sv
// VGA driver testbench covering register access, test pattern, pixel stream and buffer flags
`timescale 1ns/1ns
`default_nettype none

module vga_top_tb
  import vga_pkg::*;
();

  logic                 clk;
  logic                 rst_n;
  logic [LB_ADDR_W-1:0] addr;
  logic                 wr_en;
  logic [LB_DATA_W-1:0] wr_data;
  logic                 rd_en;
  logic [LB_DATA_W-1:0] rd_data;
  logic                 wr_valid;
  logic                 rd_valid;
  logic                 pix_valid;
  pixel_t               pix_data;
  logic                 hsync;
  logic                 vsync;
  logic                 de;
  pixel_t               rgb;

  string         test_name;
  vga_reg_word_u ctrl_model; // Expected control register
  logic          exp_uf;     // Expected sticky flags
  logic          exp_of;
  pixel_t        exp_q [$];  // Pixels pushed and not yet shown

  vga_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .addr      (addr),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .wr_valid  (wr_valid),
    .rd_valid  (rd_valid),
    .pix_valid (pix_valid),
    .pix_data  (pix_data),
    .hsync     (hsync),
    .vsync     (vsync),
    .de        (de),
    .rgb       (rgb)
  );

  always #4 clk = ~clk; // 8 ns period

  // Test pattern from raster position
  function automatic pixel_t ref_pattern(input int x, input int y);
    pixel_t p;
    p.r = x[7:0];
    p.g = y[7:0];
    p.b = p.r ^ p.g;
    return p;
  endfunction

  function automatic vga_reg_word_u status_model();
    vga_reg_word_u w;
    w = '0;
    w.status.underflow = exp_uf;
    w.status.overflow  = exp_of;
    return w;
  endfunction

  function automatic pixel_t random_pixel();
    logic [31:0] rnd;
    rnd = $urandom;
    return rnd[23:0];
  endfunction

  function automatic logic [LB_ADDR_W-1:0] random_unmapped_addr();
    logic [31:0] rnd;
    rnd = $urandom;
    if (rnd[LB_ADDR_W-1:0] == VGA_CONTROL_REG_ADDR || rnd[LB_ADDR_W-1:0] == VGA_STATUS_REG_ADDR)
      rnd[LB_ADDR_W-1:0] = 8'h08; // Keep off the register map
    return rnd[LB_ADDR_W-1:0];
  endfunction

  task automatic abort_with_failure();
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string what, input vga_reg_word_u exp,
                            input vga_reg_word_u act);
    if (exp !== act)
    begin
      $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
      abort_with_failure();
    end
  endtask

  task automatic check_pixel(input string what, input pixel_t exp, input pixel_t act);
    if (exp !== act)
    begin
      $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
      abort_with_failure();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("ERR %s %s: expected %b actual %b", test_name, what, exp, act);
      abort_with_failure();
    end
  endtask

  // Returns on the cycle wr_valid is seen
  task automatic lb_write(input logic [LB_ADDR_W-1:0] a, input logic [LB_DATA_W-1:0] d);
    int n;
    addr    = a;
    wr_data = d;
    wr_en   = 1'b1;
    @(negedge clk);
    wr_en = 1'b0;
    n     = 1;
    while (!wr_valid && n < H_TOTAL)
    begin
      @(negedge clk);
      n++;
    end
    if (!wr_valid || n != 1)
    begin
      $display("wr_valid did not follow the write strobe by one cycle in %s", test_name);
      abort_with_failure();
    end
  endtask

  task automatic lb_read(input logic [LB_ADDR_W-1:0] a, output vga_reg_word_u data);
    int n;
    addr  = a;
    rd_en = 1'b1;
    @(negedge clk);
    rd_en = 1'b0;
    n     = 1;
    while (!rd_valid && n < H_TOTAL)
    begin
      @(negedge clk);
      n++;
    end
    if (!rd_valid || n != 1)
    begin
      $display("rd_valid did not follow the read strobe by one cycle in %s", test_name);
      abort_with_failure();
    end
    data = rd_data;
    @(negedge clk);
    check_bit("rd_valid width", 1'b0, rd_valid); // Single cycle echo
  endtask

  task automatic read_check(input string what, input logic [LB_ADDR_W-1:0] a,
                            input vga_reg_word_u exp);
    vga_reg_word_u got;
    lb_read(a, got);
    check_word(what, exp, got);
  endtask

  task automatic write_ctrl(input logic en, input vga_mode_e mode);
    vga_reg_word_u w;
    w = '0;
    w.ctrl.en   = en;
    w.ctrl.mode = mode;
    lb_write(VGA_CONTROL_REG_ADDR, w);
    ctrl_model = w;
  endtask

  task automatic check_idle_video();
    check_bit("de idle", 1'b0, de);
    check_bit("hsync idle", 1'b0, hsync);
    check_bit("vsync idle", 1'b0, vsync);
    check_pixel("rgb idle", '0, rgb);
  endtask

  task automatic wait_vsync(input logic level);
    int n;
    n = 0;
    while (vsync !== level && n < 2 * H_TOTAL * V_TOTAL)
    begin
      @(negedge clk);
      n++;
    end
    if (vsync !== level)
    begin
      $display("Timeout waiting for vsync to go to %0b in %s", level, test_name);
      abort_with_failure();
    end
  endtask

  // Returns on the first blanking cycle after a visible run
  task automatic wait_line_end();
    int n;
    n = 0;
    while (!de && n < 2 * H_TOTAL * V_TOTAL)
    begin
      @(negedge clk);
      n++;
    end
    while (de && n < 2 * H_TOTAL * V_TOTAL)
    begin
      @(negedge clk);
      n++;
    end
    if (n >= 2 * H_TOTAL * V_TOTAL)
    begin
      $display("Timeout waiting for the end of a visible line in %s", test_name);
      abort_with_failure();
    end
  endtask

  // One full frame of test pattern, aligned on vsync
  task automatic check_test_frame();
    int  n;
    logic hs_seen;
    wait_vsync(1'b1);
    wait_vsync(1'b0);
    for (int y = 0; y < V_ACTIVE; y++)
    begin
      n       = 0;
      hs_seen = 1'b0;
      while (!de && n < 2 * H_TOTAL)
      begin
        if (hsync)
          hs_seen = 1'b1;
        @(negedge clk);
        n++;
      end
      if (!de)
      begin
        $display("No visible line %0d within two line times in %s", y, test_name);
        abort_with_failure();
      end
      if (y > 0)
        check_bit("hsync between lines", 1'b1, hs_seen);
      for (int x = 0; x < H_ACTIVE; x++)
      begin
        check_bit("de in line", 1'b1, de);
        check_pixel("pattern pixel", ref_pattern(x, y), rgb);
        @(negedge clk);
      end
      check_bit("de after line", 1'b0, de);
    end
  endtask

  // Compares every de pixel against pushed order, black once the queue runs dry
  task automatic stream_pixels(input int n_pix, input logic feed);
    int     seen;
    int     cyc;
    int     limit;
    pixel_t exp_pix;
    string  what;
    seen  = 0;
    cyc   = 0;
    limit = (n_pix / (H_ACTIVE * V_ACTIVE) + 2) * H_TOTAL * V_TOTAL;
    what  = feed ? "pixel order" : "pixel drain";
    while (seen < n_pix && cyc < limit)
    begin
      @(negedge clk);
      cyc++;
      if (de)
      begin
        if (exp_q.size() > 0)
          exp_pix = exp_q.pop_front();
        else
          exp_pix = '0; // Empty buffer shows black
        check_pixel(what, exp_pix, rgb);
        seen++;
      end
      // Queue depth equals buffer occupancy here
      if (feed && seen < n_pix && exp_q.size() < FIFO_DEPTH)
      begin
        pix_data  = random_pixel();
        pix_valid = 1'b1;
        exp_q.push_back(pix_data);
      end
      else
      begin
        pix_valid = 1'b0;
      end
    end
    pix_valid = 1'b0;
    if (seen < n_pix)
    begin
      $display("Only %0d of %0d visible pixels arrived in %s", seen, n_pix, test_name);
      abort_with_failure();
    end
  endtask

  initial
  begin
    logic [31:0]          rnd;
    logic [LB_ADDR_W-1:0] bad_addr;
    vga_reg_word_u        held;
    void'($urandom(3590));
    clk        = 1'b0;
    rst_n      = 1'b0;
    addr       = '0;
    wr_en      = 1'b0;
    wr_data    = '0;
    rd_en      = 1'b0;
    pix_valid  = 1'b0;
    pix_data   = '0;
    ctrl_model = '0;
    exp_uf     = 1'b0;
    exp_of     = 1'b0;

    // Video stays dark through reset and while disabled
    test_name = "reset";
    for (int i = 0; i < 10; i++)
    begin
      @(negedge clk);
      check_idle_video();
    end
    rst_n = 1'b1;
    for (int i = 0; i < 2 * H_TOTAL; i++)
    begin
      @(negedge clk);
      check_idle_video();
    end
    read_check("control after reset", VGA_CONTROL_REG_ADDR, ctrl_model);
    read_check("status after reset", VGA_STATUS_REG_ADDR, status_model());

    test_name = "register access";
    for (int i = 0; i < 8; i++)
    begin
      rnd = $urandom;
      if (rnd[0])
        rnd[1] = 1'b1; // Enable only with the pattern, so nothing pops
      check_bit("wr_valid before write", 1'b0, wr_valid);
      lb_write(VGA_CONTROL_REG_ADDR, rnd);
      ctrl_model           = '0;
      ctrl_model.ctrl.en   = rnd[0];
      ctrl_model.ctrl.mode = vga_mode_e'(rnd[1]);
      @(negedge clk);
      check_bit("wr_valid width", 1'b0, wr_valid);
      read_check("control readback", VGA_CONTROL_REG_ADDR, ctrl_model);
      bad_addr = random_unmapped_addr();
      lb_write(bad_addr, $urandom);
      read_check("control after stray write", VGA_CONTROL_REG_ADDR, ctrl_model);
      read_check("unmapped read", bad_addr, VGA_BAD_ADDR_DATA);
    end
    lb_write(VGA_STATUS_REG_ADDR, 32'hffff_ffff); // Status not writable
    read_check("control after status write", VGA_CONTROL_REG_ADDR, ctrl_model);
    read_check("status after status write", VGA_STATUS_REG_ADDR, status_model());
    held = rd_data;
    addr = bad_addr; // Unmapped word differs from the held status
    repeat (3) @(negedge clk);
    check_word("rd_data hold", held, rd_data);
    write_ctrl(1'b0, mode_normal);
    read_check("control cleared", VGA_CONTROL_REG_ADDR, ctrl_model);

    test_name = "test pattern";
    write_ctrl(1'b1, mode_test);
    check_test_frame();
    write_ctrl(1'b0, mode_normal);
    read_check("status after pattern", VGA_STATUS_REG_ADDR, status_model());

    // Prefill while disabled so the first line never starves
    test_name = "normal stream";
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      pix_data  = random_pixel();
      pix_valid = 1'b1;
      exp_q.push_back(pix_data);
      @(negedge clk);
    end
    pix_valid = 1'b0;
    write_ctrl(1'b1, mode_normal);
    stream_pixels(2 * H_ACTIVE * V_ACTIVE, 1'b1);

    test_name = "underflow";
    stream_pixels(H_ACTIVE * V_ACTIVE, 1'b0); // Leftovers then black
    exp_uf = 1'b1;
    read_check("underflow set", VGA_STATUS_REG_ADDR, status_model());
    stream_pixels(H_ACTIVE, 1'b0);
    read_check("underflow continued", VGA_STATUS_REG_ADDR, status_model());
    wait_line_end();
    write_ctrl(1'b0, mode_normal); // Lands inside horizontal blanking
    read_check("underflow after disable", VGA_STATUS_REG_ADDR, status_model());
    exp_uf = 1'b0;
    read_check("underflow cleared", VGA_STATUS_REG_ADDR, status_model());

    test_name = "overflow";
    for (int i = 0; i < FIFO_DEPTH + 2; i++)
    begin
      pix_data  = random_pixel();
      pix_valid = 1'b1;
      @(negedge clk);
    end
    pix_valid = 1'b0;
    exp_of    = 1'b1;
    read_check("overflow set", VGA_STATUS_REG_ADDR, status_model());
    exp_of = 1'b0;
    read_check("overflow cleared", VGA_STATUS_REG_ADDR, status_model());

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
common/vga_pkg.sv
common/cr_intf.sv
common/vga_ctrl_intf.sv
vga/vga_lb.sv
vga/vga_timing.sv
vga/pixel_fifo.sv
vga/vga_pixel_out.sv
design/vga_top.sv
verification/vga_top_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= vga_top_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_MSG   := all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
